// ==== build.f ====
hw/soc_pkg.sv
hw/bus_arbiter.sv
hw/addr_decoder.sv
hw/scratch_ram.sv
hw/uart_core.sv
hw/ctrl_regs.sv
hw/soc_bus.sv
bench/soc_bus_checker.sv
bench/soc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the SoC bus testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module soc_bus_tb
./obj_dir/Vsoc_bus_tb | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

// ==== bench/soc_bus_tb.sv ====
//############################################################################
// SoC bus fabric testbench
// Random CPU and DMA traffic against a reference model, arbitration,
// UART loopback, control registers and bus errors
//############################################################################

`timescale 1ns/1ns

module soc_bus_tb;

	import soc_pkg::*;

	localparam int N_RAND = 200;
	localparam int N_ARB = 16;
	localparam int N_UART = 8;
	localparam int N_ERR = 12;
	localparam int MAX_DIV = 8;
	// Worst case per transfer, idle gap and arbitration wait included
	localparam int XFER_BOUND = 16;
	localparam int WATCHDOG_CYCLES = (RAM_WORDS + N_RAND + 4 * N_ARB + N_ERR + 16) * XFER_BOUND
		+ N_UART * 40 * MAX_DIV;
	localparam logic [31:0] UART_DATA_ADDR = {REGION_UART, 28'h0};
	localparam logic [31:0] UART_DIV_ADDR = {REGION_UART, 28'h4};

	logic        clk48m;
	logic        rst;
	bus_req_t    cpu_req;
	bus_req_t    dma_req;
	bus_rsp_t    cpu_rsp;
	bus_rsp_t    dma_rsp;
	logic        uart_tx;
	logic        uart_rx;
	logic [5:0]  led;
	logic        bus_err_irq;
	logic [31:0] seed;
	logic [31:0] ram_model [RAM_WORDS];
	logic [5:0]  led_model;
	logic [31:0] err_model;
	int          errors;
	int          arb_errors = 0;
	int          last_done = -1;
	bit          other_wait = 1'b0;
	bit          arb_watch;

	// Serial loopback
	assign uart_rx = uart_tx;

	soc_bus dut0 (
		.clk48m      (clk48m),
		.rst         (rst),
		.cpu_req     (cpu_req),
		.dma_req     (dma_req),
		.uart_rx     (uart_rx),
		.cpu_rsp     (cpu_rsp),
		.dma_rsp     (dma_rsp),
		.uart_tx     (uart_tx),
		.led         (led),
		.bus_err_irq (bus_err_irq)
	);

	initial begin
		clk48m = 1'b0;
		forever begin
			#4 clk48m = ~clk48m;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk48m);
		$display("Timeout after %0d cycles, a transfer never finished", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32();
		seed = seed ^ (seed << 13);
		seed = seed ^ (seed >> 17);
		seed = seed ^ (seed << 5);
		return seed;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] wdata, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) res[8*i +: 8] = wdata[8*i +: 8];
		end
		return res;
	endfunction

	function automatic logic [31:0] ram_addr(input logic [7:0] word);
		return {REGION_RAM, 18'h0, word, 2'b00};
	endfunction

	function automatic logic [31:0] ctrl_addr(input logic [1:0] word);
		return {REGION_CTRL, 24'h0, word, 2'b00};
	endfunction

	function automatic string rsp_name(input bit dma);
		if (dma) begin
			return "dma_rsp.rdata";
		end
		return "cpu_rsp.rdata";
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		$display("CHECK FAILED %s expected %h actual %h at %0t", name, exp, act, $time);
		errors++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk48m);
			#1;
		end
	endtask

	// Starts 1 ns after an edge, returns 1 ns after the edge that took ready
	task automatic bus_xfer(input bit dma, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata);
		bus_req_t req;
		bus_rsp_t rsp;
		bit       done;
		req.valid = 1'b1;
		req.addr = addr;
		req.wdata = wdata;
		req.wstrb = wstrb;
		if (dma) dma_req = req;
		else cpu_req = req;
		done = 1'b0;
		rdata = 32'h0;
		while (!done) begin
			@(negedge clk48m);
			rsp = dma ? dma_rsp : cpu_rsp;
			if (rsp.ready) begin
				done = 1'b1;
				rdata = rsp.rdata;
			end
		end
		@(posedge clk48m);
		#1;
		if (dma) dma_req.valid = 1'b0;
		else cpu_req.valid = 1'b0;
	endtask

	// No master may win twice in a row while the other one waits
	always @(negedge clk48m) begin
		int who;
		if (arb_watch && (cpu_rsp.ready || dma_rsp.ready)) begin
			who = dma_rsp.ready ? 1 : 0;
			if (who == last_done && other_wait) begin
				$display("Arbitration unfair: master %0d served twice while the other waited",
					who);
				arb_errors++;
			end
			last_done = who;
			other_wait = (who == 1) ? cpu_req.valid : dma_req.valid;
		end
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] rd_cpu;
		logic [31:0] rd_dma;
		logic [31:0] r;
		logic [31:0] data;
		logic [31:0] div;
		logic [3:0]  strb;
		logic [3:0]  region;
		logic [7:0]  word;
		logic [31:0] cpu_data [N_ARB];
		logic [31:0] dma_data [N_ARB];
		logic [7:0]  uart_byte [N_UART];
		bit          uart_dma [N_UART];
		time         sent_time;
		bit          dma;
		int          polls;

		seed = 32'd11372;
		errors = 0;
		arb_watch = 1'b0;
		led_model = 6'h0;
		err_model = 32'h0;
		cpu_req = '0;
		dma_req = '0;
		rst = 1'b1;
		repeat (8) @(posedge clk48m);
		#1;
		rst = 1'b0;
		if (uart_tx !== 1'b1) report_mismatch("uart_tx", 32'h1, {31'h0, uart_tx});
		if (led !== 6'h0) report_mismatch("led", 32'h0, {26'h0, led});
		if (bus_err_irq !== 1'b0) report_mismatch("bus_err_irq", 32'h0, {31'h0, bus_err_irq});
		if (cpu_rsp.ready !== 1'b0 || dma_rsp.ready !== 1'b0) begin
			report_mismatch("ready", 32'h0, {30'h0, cpu_rsp.ready, dma_rsp.ready});
		end

		// Known contents in every word before the random traffic
		for (int i = 0; i < RAM_WORDS; i++) begin
			ram_model[i] = {8'hA5, 8'(i), ~8'(i), 8'(i * 7)};
			bus_xfer(1'b0, ram_addr(8'(i)), ram_model[i], 4'hF, rd);
		end

		for (int n = 0; n < N_RAND; n++) begin
			r = xorshift32();
			dma = r[0];
			word = r[15:8];
			strb = r[1] ? r[7:4] : 4'h0;
			data = xorshift32();
			bus_xfer(dma, ram_addr(word), data, strb, rd);
			if (strb == 4'h0) begin
				if (rd !== ram_model[word]) report_mismatch(rsp_name(dma), ram_model[word], rd);
			end else begin
				ram_model[word] = merge_bytes(ram_model[word], data, strb);
			end
			idle_cycles(int'(r[19:18]));
		end

		// Back-to-back write streams from both masters at once
		for (int i = 0; i < N_ARB; i++) begin
			cpu_data[i] = xorshift32();
			dma_data[i] = xorshift32();
		end
		arb_watch = 1'b1;
		fork
			begin
				for (int i = 0; i < N_ARB; i++) begin
					bus_xfer(1'b0, ram_addr(8'(32 + i)), cpu_data[i], 4'hF, rd_cpu);
				end
			end
			begin
				for (int i = 0; i < N_ARB; i++) begin
					bus_xfer(1'b1, ram_addr(8'(160 + i)), dma_data[i], 4'hF, rd_dma);
				end
			end
		join
		arb_watch = 1'b0;
		for (int i = 0; i < N_ARB; i++) begin
			ram_model[32 + i] = cpu_data[i];
			ram_model[160 + i] = dma_data[i];
			bus_xfer(1'b1, ram_addr(8'(32 + i)), 32'h0, 4'h0, rd);
			if (rd !== cpu_data[i]) report_mismatch("dma_rsp.rdata", cpu_data[i], rd);
			bus_xfer(1'b0, ram_addr(8'(160 + i)), 32'h0, 4'h0, rd);
			if (rd !== dma_data[i]) report_mismatch("cpu_rsp.rdata", dma_data[i], rd);
		end

		div = 32'd4 + (xorshift32() % 32'd5);
		bus_xfer(1'b0, UART_DIV_ADDR, div, 4'hF, rd);
		bus_xfer(1'b0, UART_DIV_ADDR, 32'h0, 4'h0, rd);
		if (rd !== div) report_mismatch("cpu_rsp.rdata", div, rd);
		for (int n = 0; n < N_UART; n++) begin
			r = xorshift32();
			uart_byte[n] = r[7:0];
			uart_dma[n] = r[8];
		end
		bus_xfer(uart_dma[0], UART_DATA_ADDR, {24'h0, uart_byte[0]}, 4'h1, rd);
		sent_time = $time;
		for (int n = 0; n < N_UART; n++) begin
			dma = uart_dma[n];
			data = {24'h0, uart_byte[n]};
			// Next byte goes out while this frame is still on the line
			if (n + 1 < N_UART) begin
				bus_xfer(uart_dma[n + 1], UART_DATA_ADDR, {24'h0, uart_byte[n + 1]}, 4'h1, rd);
				// Ten bit times of 8 ns clocks
				if ($time - sent_time < 10 * div * 8) begin
					$display("UART data write %0d finished before the previous frame ended",
						n + 1);
					errors++;
				end
				sent_time = $time;
			end
			polls = 0;
			rd = UART_EMPTY;
			while (rd === UART_EMPTY && polls < 40 * MAX_DIV) begin
				bus_xfer(dma, UART_DATA_ADDR, 32'h0, 4'h0, rd);
				polls++;
			end
			if (rd === UART_EMPTY) begin
				$display("UART byte %0d never showed up in the receive buffer", n);
				errors++;
			end else if (rd !== data) begin
				report_mismatch(rsp_name(dma), data, rd);
			end
			bus_xfer(dma, UART_DATA_ADDR, 32'h0, 4'h0, rd);
			if (rd !== UART_EMPTY) report_mismatch(rsp_name(dma), UART_EMPTY, rd);
		end

		r = xorshift32();
		led_model = r[5:0];
		bus_xfer(1'b1, ctrl_addr(CTRL_LED), r, 4'h1, rd);
		if (led !== led_model) report_mismatch("led", {26'h0, led_model}, {26'h0, led});
		bus_xfer(1'b0, ctrl_addr(CTRL_LED), 32'h0, 4'h0, rd);
		if (rd !== {26'h0, led_model}) report_mismatch("cpu_rsp.rdata", {26'h0, led_model}, rd);
		bus_xfer(1'b1, ctrl_addr(CTRL_VERSION), 32'h0, 4'h0, rd);
		if (rd !== SOC_VERSION) report_mismatch("dma_rsp.rdata", SOC_VERSION, rd);

		for (int n = 0; n < N_ERR; n++) begin
			r = xorshift32();
			region = r[31:28];
			// Mapped nibbles move to 9, A or C
			if (region == REGION_RAM || region == REGION_UART || region == REGION_CTRL) begin
				region = region ^ 4'h8;
			end
			strb = r[0] ? 4'h0 : r[7:4];
			dma = r[1];
			data = xorshift32();
			bus_xfer(dma, {region, r[27:0]}, data, strb, rd);
			err_model = err_model + 32'd1;
			if (strb == 4'h0 && rd !== BUS_ERR_DATA) report_mismatch(rsp_name(dma), BUS_ERR_DATA, rd);
			@(negedge clk48m);
			if (bus_err_irq !== 1'b1) report_mismatch("bus_err_irq", 32'h1, {31'h0, bus_err_irq});
			@(negedge clk48m);
			if (bus_err_irq !== 1'b0) report_mismatch("bus_err_irq", 32'h0, {31'h0, bus_err_irq});
			@(posedge clk48m);
			#1;
		end
		bus_xfer(1'b0, ctrl_addr(CTRL_ERRCNT), 32'h0, 4'h0, rd);
		if (rd !== err_model) report_mismatch("cpu_rsp.rdata", err_model, rd);

		$display("Run complete: %0d check errors, %0d arbitration errors", errors, arb_errors);
		if (errors == 0 && arb_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== bench/soc_bus_checker.sv ====
//############################################################################
// SoC bus checker
// Protocol assertions on both master ports, the grant and the error irq
//############################################################################

`timescale 1ns/1ns

module soc_bus_checker (
	input logic              clk48m,
	input logic              rst,
	input soc_pkg::bus_req_t cpu_req,
	input soc_pkg::bus_req_t dma_req,
	input soc_pkg::bus_rsp_t cpu_rsp,
	input soc_pkg::bus_rsp_t dma_rsp,
	input logic [1:0]        grant,
	input logic              bus_err_irq
);

	// One owner, kept without going two-hot until its transfer sees ready
	grant_held: assert property (@(posedge clk48m) disable iff (rst)
		(grant[0] && !cpu_rsp.ready) || (grant[1] && !dma_rsp.ready)
		|=> grant == $past(grant))
		else $error("grant moved or went two-hot during an open transfer");

	// Request held until the edge that sees ready
	cpu_req_stable: assert property (@(posedge clk48m) disable iff (rst)
		cpu_req.valid && !cpu_rsp.ready |=> $stable(cpu_req))
		else $error("cpu_req changed while waiting for ready");

	dma_req_stable: assert property (@(posedge clk48m) disable iff (rst)
		dma_req.valid && !dma_rsp.ready |=> $stable(dma_req))
		else $error("dma_req changed while waiting for ready");

	ready_needs_valid: assert property (@(posedge clk48m) disable iff (rst)
		!(cpu_rsp.ready && !cpu_req.valid) && !(dma_rsp.ready && !dma_req.valid))
		else $error("ready high without valid");

	irq_one_cycle: assert property (@(posedge clk48m) disable iff (rst)
		bus_err_irq |=> !bus_err_irq)
		else $error("bus_err_irq high for two cycles");

endmodule

bind soc_bus soc_bus_checker chk0 (
	.clk48m      (clk48m),
	.rst         (rst),
	.cpu_req     (cpu_req),
	.dma_req     (dma_req),
	.cpu_rsp     (cpu_rsp),
	.dma_rsp     (dma_rsp),
	.grant       (grant),
	.bus_err_irq (bus_err_irq)
);

// ==== hw/soc_bus.sv ====
//############################################################################
// SoC bus fabric top
// CPU and DMA ports share one bus into scratch RAM, UART and control regs
//############################################################################

`timescale 1ns/1ns

module soc_bus (
	input  logic              clk48m,
	input  logic              rst,
	input  soc_pkg::bus_req_t cpu_req,
	input  soc_pkg::bus_req_t dma_req,
	input  logic              uart_rx,
	output soc_pkg::bus_rsp_t cpu_rsp,
	output soc_pkg::bus_rsp_t dma_rsp,
	output logic              uart_tx,
	output logic [5:0]        led,
	output logic              bus_err_irq
);

	import soc_pkg::*;

	bus_req_t    bus_req;
	bus_rsp_t    bus_rsp;
	logic [1:0]  grant;
	logic        ram_sel;
	logic        uart_sel;
	logic        uart_div;
	logic        ctrl_sel;
	logic        bus_err;
	logic [31:0] ram_rdata;
	logic [31:0] uart_rdata;
	logic [31:0] ctrl_rdata;
	logic        ram_ready;
	logic        uart_ready;

	bus_arbiter arb0 (
		.clk48m  (clk48m),
		.rst     (rst),
		.cpu_req (cpu_req),
		.dma_req (dma_req),
		.bus_rsp (bus_rsp),
		.cpu_rsp (cpu_rsp),
		.dma_rsp (dma_rsp),
		.bus_req (bus_req),
		.grant   (grant)
	);

	addr_decoder dec0 (
		.bus_req    (bus_req),
		.ram_rdata  (ram_rdata),
		.uart_rdata (uart_rdata),
		.ctrl_rdata (ctrl_rdata),
		.ram_ready  (ram_ready),
		.uart_ready (uart_ready),
		.bus_rsp    (bus_rsp),
		.ram_sel    (ram_sel),
		.uart_sel   (uart_sel),
		.uart_div   (uart_div),
		.ctrl_sel   (ctrl_sel),
		.bus_err    (bus_err)
	);

	// Word address inside the RAM region
	scratch_ram ram0 (
		.clk48m (clk48m),
		.rst    (rst),
		.sel    (ram_sel),
		.addr   (bus_req.addr[RAM_AW+1:2]),
		.wdata  (bus_req.wdata),
		.wstrb  (bus_req.wstrb),
		.rdata  (ram_rdata),
		.ready  (ram_ready)
	);

	uart_core uart0 (
		.clk48m  (clk48m),
		.rst     (rst),
		.sel     (uart_sel),
		.div_sel (uart_div),
		.wdata   (bus_req.wdata),
		.wstrb   (bus_req.wstrb),
		.rx      (uart_rx),
		.rdata   (uart_rdata),
		.ready   (uart_ready),
		.tx      (uart_tx)
	);

	ctrl_regs ctrl0 (
		.clk48m  (clk48m),
		.rst     (rst),
		.sel     (ctrl_sel),
		.bus_err (bus_err),
		.word    (bus_req.addr[3:2]),
		.wdata   (bus_req.wdata),
		.wstrb   (bus_req.wstrb),
		.rdata   (ctrl_rdata),
		.led     (led),
		.irq     (bus_err_irq)
	);

endmodule

// ==== hw/ctrl_regs.sv ====
//############################################################################
// Control registers
// LED register, version word, bus-error counter and the error interrupt
//############################################################################

`timescale 1ns/1ns

module ctrl_regs (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sel,
	input  logic        bus_err,
	input  logic [1:0]  word,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic [31:0] rdata,
	output logic [5:0]  led,
	output logic        irq
);

	import soc_pkg::*;

	logic [31:0] err_cnt;

	always_comb begin
		case (word)
			CTRL_LED:     rdata = {26'h0, led};
			CTRL_VERSION: rdata = SOC_VERSION;
			CTRL_ERRCNT:  rdata = err_cnt;
			default:      rdata = 32'h0;
		endcase
	end

	// bus_err is high for exactly one cycle per error transfer
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= 6'h0;
			err_cnt <= 32'h0;
			irq <= 1'b0;
		end else begin
			irq <= bus_err;
			if (bus_err) begin
				err_cnt <= err_cnt + 32'd1;
			end
			if (sel && wstrb[0] && word == CTRL_LED) begin
				led <= wdata[5:0];
			end
		end
	end

endmodule

// ==== hw/uart_core.sv ====
//############################################################################
// UART core
// 8N1 transmitter and receiver with a divider register and a one-byte
// receive buffer, data writes stall while the transmitter is busy
//############################################################################

`timescale 1ns/1ns

module uart_core (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sel,
	input  logic        div_sel,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        rx,
	output logic [31:0] rdata,
	output logic        ready,
	output logic        tx
);

	import soc_pkg::*;

	logic [31:0] div_reg;
	logic        div_we;
	logic        dat_we;
	logic        dat_re;
	logic [9:0]  tx_shift;
	logic [3:0]  tx_cnt;
	logic [31:0] tx_div_cnt;
	logic        tx_busy;
	logic        rx_s1;
	logic        rx_s2;
	logic [3:0]  rx_state;
	logic [31:0] rx_div_cnt;
	logic        rx_tick;
	logic        rx_bit;
	logic        rx_done;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_buf;
	logic        rx_valid;

	assign div_we = sel && div_sel;
	assign dat_we = sel && !div_sel && wstrb[0];
	assign dat_re = sel && !div_sel && (wstrb == 4'b0000);
	assign tx_busy = (tx_cnt != 4'd0);
	assign ready = sel && !(dat_we && tx_busy);
	assign tx = tx_shift[0];

	always_comb begin
		if (div_sel) begin
			rdata = div_reg;
		end else begin
			rdata = rx_valid ? {24'h0, rx_buf} : UART_EMPTY;
		end
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			div_reg <= UART_DIV_RESET;
		end else if (div_we) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					div_reg[8*i +: 8] <= wdata[8*i +: 8];
				end
			end
		end
	end

	// Frame is start, eight data bits LSB first, stop
	always_ff @(posedge clk48m) begin
		if (rst) begin
			tx_shift <= '1;
			tx_cnt <= 4'd0;
			tx_div_cnt <= '0;
		end else if (dat_we && !tx_busy) begin
			tx_shift <= {1'b1, wdata[7:0], 1'b0};
			tx_cnt <= 4'd10;
			tx_div_cnt <= '0;
		end else if (tx_busy) begin
			if (tx_div_cnt >= div_reg - 32'd1) begin
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx_cnt <= tx_cnt - 4'd1;
				tx_div_cnt <= '0;
			end else begin
				tx_div_cnt <= tx_div_cnt + 32'd1;
			end
		end
	end

	// State 0 idle, 1 start bit, 2 to 9 data bits, 10 stop bit
	assign rx_tick = (rx_div_cnt >= div_reg);
	assign rx_bit = (rx_state >= 4'd2) && (rx_state <= 4'd9) && rx_tick;
	assign rx_done = (rx_state == 4'd10) && rx_tick && rx_s2;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
			rx_state <= 4'd0;
			rx_div_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_s1 <= rx;
			rx_s2 <= rx_s1;
			rx_div_cnt <= rx_div_cnt + 32'd1;
			if (rx_state == 4'd0) begin
				rx_div_cnt <= 32'd1;
				if (!rx_s2) begin
					rx_state <= 4'd1;
				end
			end else if (rx_state == 4'd1) begin
				// Start bit must still be low at mid-bit
				if (rx_div_cnt >= {1'b0, div_reg[31:1]}) begin
					rx_div_cnt <= 32'd1;
					rx_state <= rx_s2 ? 4'd0 : 4'd2;
				end
			end else if (rx_tick) begin
				rx_div_cnt <= 32'd1;
				rx_state <= (rx_state == 4'd10) ? 4'd0 : rx_state + 4'd1;
			end
			// A new byte wins over a read in the same cycle
			if (rx_done) begin
				rx_valid <= 1'b1;
			end else if (dat_re) begin
				rx_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (rx_bit) begin
			rx_shift <= {rx_s2, rx_shift[7:1]};
		end
		if (rx_done) begin
			rx_buf <= rx_shift;
		end
	end

endmodule

// ==== hw/scratch_ram.sv ====
//############################################################################
// Scratch RAM
// Word memory with byte strobes, one registered response per access
//############################################################################

`timescale 1ns/1ns

module scratch_ram (
	input  logic                       clk48m,
	input  logic                       rst,
	input  logic                       sel,
	input  logic [soc_pkg::RAM_AW-1:0] addr,
	input  logic [31:0]                wdata,
	input  logic [3:0]                 wstrb,
	output logic [31:0]                rdata,
	output logic                       ready
);

	import soc_pkg::*;

	logic [31:0] mem [RAM_WORDS];
	logic        access;

	// First cycle of a select, the ready cycle itself is not a new access
	assign access = sel && !ready;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ready <= 1'b0;
		end else begin
			ready <= access;
		end
	end

	always_ff @(posedge clk48m) begin
		if (access) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i]) begin
					mem[addr][8*i +: 8] <= wdata[8*i +: 8];
				end
			end
			rdata <= mem[addr];
		end
	end

endmodule

// ==== hw/addr_decoder.sv ====
//############################################################################
// Address decoder
// Splits the granted request into RAM, UART and control selects, muxes
// the region response back and flags accesses to unmapped space
//############################################################################

`timescale 1ns/1ns

module addr_decoder (
	input  soc_pkg::bus_req_t bus_req,
	input  logic [31:0]       ram_rdata,
	input  logic [31:0]       uart_rdata,
	input  logic [31:0]       ctrl_rdata,
	input  logic              ram_ready,
	input  logic              uart_ready,
	output soc_pkg::bus_rsp_t bus_rsp,
	output logic              ram_sel,
	output logic              uart_sel,
	output logic              uart_div,
	output logic              ctrl_sel,
	output logic              bus_err
);

	import soc_pkg::*;

	logic [3:0] region;

	assign region = bus_req.addr[31:28];

	// Bit 2 set picks the divider register, clear picks data
	assign uart_div = bus_req.addr[2];

	always_comb begin
		ram_sel = 1'b0;
		uart_sel = 1'b0;
		ctrl_sel = 1'b0;
		bus_err = 1'b0;
		case (region)
			REGION_RAM: begin
				ram_sel = bus_req.valid;
			end
			REGION_UART: begin
				uart_sel = bus_req.valid;
			end
			REGION_CTRL: begin
				ctrl_sel = bus_req.valid;
			end
			default: begin
				bus_err = bus_req.valid;
			end
		endcase
	end

	always_comb begin
		case (region)
			REGION_RAM:  bus_rsp.rdata = ram_rdata;
			REGION_UART: bus_rsp.rdata = uart_rdata;
			REGION_CTRL: bus_rsp.rdata = ctrl_rdata;
			default:     bus_rsp.rdata = BUS_ERR_DATA;
		endcase
		// Control registers and bus errors answer in the same cycle
		bus_rsp.ready = (ram_sel && ram_ready)
			|| (uart_sel && uart_ready)
			|| ctrl_sel
			|| bus_err;
	end

endmodule

// ==== hw/bus_arbiter.sv ====
//############################################################################
// Bus arbiter
// Shares the memory bus between the CPU and DMA ports, round-robin on
// simultaneous requests, grant held until the open transfer sees ready
//############################################################################

`timescale 1ns/1ns

module bus_arbiter (
	input  logic              clk48m,
	input  logic              rst,
	input  soc_pkg::bus_req_t cpu_req,
	input  soc_pkg::bus_req_t dma_req,
	input  soc_pkg::bus_rsp_t bus_rsp,
	output soc_pkg::bus_rsp_t cpu_rsp,
	output soc_pkg::bus_rsp_t dma_rsp,
	output soc_pkg::bus_req_t bus_req,
	output logic [1:0]        grant
);

	// High when DMA got the last completed transfer
	logic last_dma;
	logic locked;
	logic lock_owner;

	always_comb begin
		grant = 2'b00;
		if (locked) begin
			grant = lock_owner ? 2'b10 : 2'b01;
		end else if (cpu_req.valid && dma_req.valid) begin
			// The master not served last goes first
			grant = last_dma ? 2'b01 : 2'b10;
		end else if (cpu_req.valid) begin
			grant = 2'b01;
		end else if (dma_req.valid) begin
			grant = 2'b10;
		end
	end

	always_comb begin
		bus_req = '0;
		if (grant[1]) begin
			bus_req = dma_req;
		end else if (grant[0]) begin
			bus_req = cpu_req;
		end
		cpu_rsp.rdata = bus_rsp.rdata;
		cpu_rsp.ready = grant[0] && bus_rsp.ready;
		dma_rsp.rdata = bus_rsp.rdata;
		dma_rsp.ready = grant[1] && bus_rsp.ready;
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			last_dma <= 1'b0;
			locked <= 1'b0;
			lock_owner <= 1'b0;
		end else if (grant != 2'b00) begin
			if (bus_rsp.ready) begin
				locked <= 1'b0;
				last_dma <= grant[1];
			end else begin
				// Transfer still open, keep the same master
				locked <= 1'b1;
				lock_owner <= grant[1];
			end
		end
	end

endmodule

// ==== hw/soc_pkg.sv ====
//############################################################################
// SoC bus package
// Request and response structs of the shared memory bus, the address map,
// control register offsets and the fixed constants of the fabric
//############################################################################

package soc_pkg;

	// One request on the memory bus, a zero wstrb is a read
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
	} bus_req_t;

	// Response of the selected region
	typedef struct packed {
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

	// Regions by address bits 31:28
	localparam logic [3:0] REGION_RAM  = 4'h4;
	localparam logic [3:0] REGION_UART = 4'h1;
	localparam logic [3:0] REGION_CTRL = 4'h2;

	// Scratch RAM geometry in 32-bit words
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

	// Control block word offsets, address bits 3:2
	localparam logic [1:0] CTRL_LED    = 2'd0;
	localparam logic [1:0] CTRL_VERSION = 2'd1;
	localparam logic [1:0] CTRL_ERRCNT = 2'd2;

	localparam logic [31:0] SOC_VERSION  = 32'h0000_8000;
	localparam logic [31:0] BUS_ERR_DATA = 32'hDEAD_BEEF;

	// UART data register value with nothing received
	localparam logic [31:0] UART_EMPTY = 32'hFFFF_FFFF;

	// Divider after reset, clocks per serial bit
	localparam logic [31:0] UART_DIV_RESET = 32'd4;

endpackage
